// File: hdl/line_ram_pkg.sv
// ==============================
// Shared definitions for the Wishbone line RAM
// Widths, latency and memory size
// Wishbone cycle type codes
// Request, response and line write structs
// Burst FSM state encoding
// ==============================

package line_ram_pkg;

  // ==============================
  // Sizes and timing
  // ==============================

  // Wishbone data word
  localparam int WORD_W = 32;
  // One cache line of the store
  localparam int LINE_W = 128;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int BYTES_PER_WORD = WORD_W / 8;

  // 4 KiB total
  localparam int RAM_DEPTH_WORDS = 1024;
  localparam int LINE_DEPTH = RAM_DEPTH_WORDS / WORDS_PER_LINE;

  // Read delay chain length, two or more
  localparam int RAM_LATENCY = 16;

  // Address slicing
  localparam int BYTE_OFF_W = $clog2(BYTES_PER_WORD);
  localparam int WORD_OFF_W = $clog2(WORDS_PER_LINE);
  localparam int LINE_IDX_W = $clog2(LINE_DEPTH);
  localparam int LINE_IDX_LSB = BYTE_OFF_W + WORD_OFF_W;

  // Wishbone B4 cycle type identifiers
  localparam logic [2:0] WB_CTI_CLASSIC = 3'b000;
  localparam logic [2:0] WB_CTI_INCR = 3'b010;
  localparam logic [2:0] WB_CTI_EOB = 3'b111;

  // ==============================
  // Vector types
  // ==============================
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0] byte_addr_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_sel_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [LINE_W/8-1:0] line_strb_t;
  typedef logic [LINE_IDX_W-1:0] line_idx_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;
  typedef logic [2:0] cti_t;
  typedef logic [RAM_LATENCY-1:0] delay_t;

  // ==============================
  // Bundles
  // ==============================

  // Master side of the slave port
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    byte_addr_t adr;
    word_t      dat;
    byte_sel_t  sel;
    cti_t       cti;
  } wb_req_t;

  // Slave answer, err/rty/stall not used
  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  // Line-wide write with byte strobes
  typedef struct packed {
    line_idx_t  idx;
    line_t      data;
    line_strb_t strb;
  } line_wr_t;

  // Burst tracking
  typedef enum logic [1:0] {
    BURST_IDLE,
    BURST_FETCH,
    BURST_HELD
  } burst_state_e;

endpackage

// File: hdl/wb_lane_expand.sv
// ==============================
// Wishbone lane expander
// Word request to line write
// Read issue strobe for the store
// ==============================
`timescale 1ns/100ps

module wb_lane_expand (
  input  line_ram_pkg::wb_req_t  wb_req_i,
  input  logic                   line_held_i,
  output line_ram_pkg::line_wr_t line_wr_o,
  output logic                   wr_en_o,
  output logic                   rd_issue_o
);

  logic                    req_valid;
  line_ram_pkg::word_off_t word_off;

  // Valid while cyc and stb both high
  assign req_valid = wb_req_i.cyc && wb_req_i.stb;

  // Word position inside the line
  assign word_off = wb_req_i.adr[line_ram_pkg::BYTE_OFF_W +: line_ram_pkg::WORD_OFF_W];

  // ==============================
  // Line write build
  // ==============================
  always_comb begin
    line_wr_o.idx  = wb_req_i.adr[line_ram_pkg::LINE_IDX_LSB +: line_ram_pkg::LINE_IDX_W];
    line_wr_o.data = '0;
    line_wr_o.strb = '0;

    // Same word in every lane, strobes pick the one that lands
    for (int w = 0; w < line_ram_pkg::WORDS_PER_LINE; w++) begin
      line_wr_o.data[w*line_ram_pkg::WORD_W +: line_ram_pkg::WORD_W] = wb_req_i.dat;
    end

    // Byte selects steered to the addressed word
    if (req_valid && wb_req_i.we) begin
      line_wr_o.strb[word_off*line_ram_pkg::BYTES_PER_WORD +: line_ram_pkg::BYTES_PER_WORD] =
        wb_req_i.sel;
    end
  end

  // ==============================
  // Strobes
  // ==============================

  // Writes go straight into the store
  assign wr_en_o = req_valid && wb_req_i.we;

  // No fetch while a burst line is buffered
  assign rd_issue_o = req_valid && !wb_req_i.we && !line_held_i;

endmodule

// File: hdl/line_store.sv
// ==============================
// Line store
// Byte-strobed line writes
// Registered line read on issue
// ==============================
`timescale 1ns/100ps

module line_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  line_ram_pkg::line_wr_t line_wr_i,
  input  logic                   wr_en_i,
  input  logic                   rd_issue_i,
  output line_ram_pkg::line_t    rd_line_o
);

  // Storage, one entry per cache line
  line_ram_pkg::line_t mem_q [line_ram_pkg::LINE_DEPTH];

  // ==============================
  // Write port
  // ==============================

  // Per-byte enables from the line strobe
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < line_ram_pkg::LINE_W / 8; b++) begin
        if (line_wr_i.strb[b]) begin
          mem_q[line_wr_i.idx][b*8 +: 8] <= line_wr_i.data[b*8 +: 8];
        end
      end
    end
  end

  // ==============================
  // Read port
  // ==============================

  // One cycle read, then held until the next issue
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_line_o <= '0;
    end else if (rd_issue_i) begin
      rd_line_o <= mem_q[line_wr_i.idx];
    end
  end

endmodule

// File: hdl/read_latency_pipe.sv
// ==============================
// Read latency pipeline
// Pending flag plus delay chain
// Times the first read ack
// ==============================
`timescale 1ns/100ps

module read_latency_pipe (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rd_issue_i,
  input  logic ack_i,
  output logic line_ready_o
);

  logic                 pending_q;
  line_ram_pkg::delay_t delay_q;

  // ==============================
  // Delay chain
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else if (ack_i) begin
      // Flush so a still-held request is not fetched twice
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      pending_q <= rd_issue_i;
      // Pending walks toward the top bit
      delay_q   <= {delay_q[line_ram_pkg::RAM_LATENCY-2:0], pending_q};
    end
  end

  // Top of the chain marks the line as ready
  assign line_ready_o = delay_q[line_ram_pkg::RAM_LATENCY-1];

endmodule

// File: hdl/burst_line_buffer.sv
// ==============================
// Burst line buffer
// Captures the fetched line
// Burst FSM and word select
// Wishbone ack generation
// ==============================
`timescale 1ns/100ps

module burst_line_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  line_ram_pkg::wb_req_t wb_req_i,
  input  line_ram_pkg::line_t   rd_line_i,
  input  logic                  line_ready_i,
  output logic                  line_held_o,
  output line_ram_pkg::wb_rsp_t wb_rsp_o
);

  line_ram_pkg::burst_state_e state_q;
  line_ram_pkg::burst_state_e state_d;
  line_ram_pkg::line_t        line_q;
  line_ram_pkg::line_t        src_line;
  line_ram_pkg::word_off_t    word_off;
  logic                       req_valid;
  logic                       rd_req;
  logic                       wr_ack;
  logic                       beat_ack;

  // ==============================
  // Request decode
  // ==============================
  assign req_valid = wb_req_i.cyc && wb_req_i.stb;
  assign rd_req    = req_valid && !wb_req_i.we;
  assign word_off  = wb_req_i.adr[line_ram_pkg::BYTE_OFF_W +: line_ram_pkg::WORD_OFF_W];

  // Writes complete in the cycle they appear
  assign wr_ack = req_valid && wb_req_i.we;

  // Later burst beats served from the buffer
  assign beat_ack = (state_q == line_ram_pkg::BURST_HELD) && rd_req &&
                    (wb_req_i.cti != line_ram_pkg::WB_CTI_CLASSIC);

  // ==============================
  // Burst FSM
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      line_ram_pkg::BURST_IDLE: begin
        if (rd_req) begin
          state_d = line_ram_pkg::BURST_FETCH;
        end
      end
      line_ram_pkg::BURST_FETCH: begin
        // First beat acked here
        if (line_ready_i) begin
          if (wb_req_i.cti == line_ram_pkg::WB_CTI_INCR) begin
            state_d = line_ram_pkg::BURST_HELD;
          end else begin
            state_d = line_ram_pkg::BURST_IDLE;
          end
        end
      end
      line_ram_pkg::BURST_HELD: begin
        // Release on the last beat
        if (beat_ack && (wb_req_i.cti == line_ram_pkg::WB_CTI_EOB)) begin
          state_d = line_ram_pkg::BURST_IDLE;
        end
      end
      default: begin
        state_d = line_ram_pkg::BURST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= line_ram_pkg::BURST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Line capture as the fetch completes
  always_ff @(posedge clk_i) begin
    if (line_ready_i) begin
      line_q <= rd_line_i;
    end
  end

  // Stops new fetches in lane expander
  assign line_held_o = (state_q == line_ram_pkg::BURST_HELD);

  // ==============================
  // Response
  // ==============================

  // First beat straight from the store, later beats from the buffer
  assign src_line = line_held_o ? line_q : rd_line_i;

  always_comb begin
    wb_rsp_o.dat = src_line[word_off*line_ram_pkg::WORD_W +: line_ram_pkg::WORD_W];
    wb_rsp_o.ack = wr_ack || line_ready_i || beat_ack;
  end

endmodule

// File: hdl/wb_line_ram.sv
// ==============================
// Wishbone line RAM top level
// Lane expander, line store,
// latency pipe and burst buffer
// ==============================
`timescale 1ns/100ps

module wb_line_ram (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  line_ram_pkg::wb_req_t wb_req_i,
  output line_ram_pkg::wb_rsp_t wb_rsp_o
);

  // ==============================
  // Stage interconnect
  // ==============================
  line_ram_pkg::line_wr_t line_wr;
  line_ram_pkg::line_t    rd_line;
  line_ram_pkg::wb_rsp_t  wb_rsp;
  logic                   wr_en;
  logic                   rd_issue;
  logic                   line_held;
  logic                   line_ready;

  // Request to line write and fetch strobe
  wb_lane_expand u_lane_expand (
    .wb_req_i   (wb_req_i),
    .line_held_i(line_held),
    .line_wr_o  (line_wr),
    .wr_en_o    (wr_en),
    .rd_issue_o (rd_issue)
  );

  // Line memory
  line_store u_line_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .line_wr_i (line_wr),
    .wr_en_i   (wr_en),
    .rd_issue_i(rd_issue),
    .rd_line_o (rd_line)
  );

  // First read ack timing
  read_latency_pipe u_latency_pipe (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_issue_i  (rd_issue),
    .ack_i       (wb_rsp.ack),
    .line_ready_o(line_ready)
  );

  // Burst tracking and response
  burst_line_buffer u_burst_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_i    (wb_req_i),
    .rd_line_i   (rd_line),
    .line_ready_i(line_ready),
    .line_held_o (line_held),
    .wb_rsp_o    (wb_rsp)
  );

  assign wb_rsp_o = wb_rsp;

endmodule

// File: sim/tb_wb_line_ram_tasks.svh
// ==============================
// Testbench helpers
// Galois LFSR random source
// Reference word memory model
// Wishbone write, read and burst
// ==============================

// LFSR state
logic [31:0] lfsr_q = 32'h1e67;

// Reference copy of the store, one entry per word
line_ram_pkg::word_t model_mem [line_ram_pkg::RAM_DEPTH_WORDS];

// One Galois step, taps x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

// n random bits, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val    = {val[30:0], lfsr_q[0]};
    lfsr_q = lfsr_next(lfsr_q);
  end
  return val;
endfunction

// Word slot, address wraps at the memory size
function automatic int model_index(input line_ram_pkg::byte_addr_t adr);
  return int'(adr[31:2]) % line_ram_pkg::RAM_DEPTH_WORDS;
endfunction

function automatic line_ram_pkg::word_t model_word(input line_ram_pkg::byte_addr_t adr);
  return model_mem[model_index(adr)];
endfunction

// Only the selected bytes change
function automatic void model_write(input line_ram_pkg::byte_addr_t adr,
                                    input line_ram_pkg::word_t dat,
                                    input line_ram_pkg::byte_sel_t sel);
  int idx;
  idx = model_index(adr);
  for (int b = 0; b < line_ram_pkg::BYTES_PER_WORD; b++) begin
    if (sel[b]) begin
      model_mem[idx][b*8 +: 8] = dat[b*8 +: 8];
    end
  end
endfunction

// Fill value mixing all address bits
function automatic line_ram_pkg::word_t fill_pattern(input line_ram_pkg::byte_addr_t adr);
  return (adr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
endfunction

// ==============================
// Bus cycles
// ==============================

// Rising edges passed until ack shows, sampled at the falling edge
task automatic wait_ack(input string what, output int edges);
  edges = 0;
  @(negedge clk_i);
  while (wb_rsp.ack !== 1'b1) begin
    if (edges >= ACK_TIMEOUT) begin
      abort_run($sformatf("no ack for %s within %0d cycles", what, ACK_TIMEOUT));
    end
    @(posedge clk_i);
    edges++;
    @(negedge clk_i);
  end
endtask

task automatic wb_write(input line_ram_pkg::byte_addr_t adr, input line_ram_pkg::word_t dat,
                        input line_ram_pkg::byte_sel_t sel, output int edges);
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = 1'b1;
  wb_req.adr = adr;
  wb_req.dat = dat;
  wb_req.sel = sel;
  wb_req.cti = line_ram_pkg::WB_CTI_CLASSIC;
  wait_ack("write", edges);
  // Store takes the write on this edge
  @(posedge clk_i);
  #1;
  wb_req = '0;
  model_write(adr, dat, sel);
endtask

task automatic wb_read(input line_ram_pkg::byte_addr_t adr, output line_ram_pkg::word_t dat,
                       output int edges);
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = 1'b0;
  wb_req.adr = adr;
  wb_req.sel = '1;
  wb_req.cti = line_ram_pkg::WB_CTI_CLASSIC;
  wait_ack("single read", edges);
  dat = wb_rsp.dat;
  @(posedge clk_i);
  #1;
  wb_req = '0;
endtask

// Consecutive words, EOB on the last beat
task automatic wb_burst(input line_ram_pkg::byte_addr_t adr, input int beats, input logic gap);
  for (int i = 0; i < beats; i++) begin
    if (gap && i > 0) begin
      // Master holds off a cycle, cyc stays high and no ack may come
      wb_req.stb = 1'b0;
      @(negedge clk_i);
      check_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);
      @(posedge clk_i);
      #1;
    end
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr + line_ram_pkg::byte_addr_t'(4 * i);
    wb_req.sel = '1;
    wb_req.cti = (i == beats - 1) ? line_ram_pkg::WB_CTI_EOB : line_ram_pkg::WB_CTI_INCR;
    wait_ack("burst beat", burst_edges[i]);
    burst_dat[i] = wb_rsp.dat;
    @(posedge clk_i);
    #1;
  end
  wb_req = '0;
endtask

// File: sim/tb_wb_line_ram.sv
// ==============================
// Testbench for the Wishbone line RAM
// Clock, reset and DUT instance
// Check tasks and run summary
// Directed tests and random mix
// ==============================
`timescale 1ns/100ps

module tb_wb_line_ram;

  // Every wait gives up after this many cycles
  localparam int ACK_TIMEOUT = line_ram_pkg::RAM_LATENCY + 20;
  // Edges from request to first read ack
  localparam int READ_EDGES = line_ram_pkg::RAM_LATENCY + 1;

  logic                  clk_i;
  logic                  rst_ni;
  line_ram_pkg::wb_req_t wb_req;
  line_ram_pkg::wb_rsp_t wb_rsp;

  // Result counters
  int err_cnt;
  int tests_ok;
  int tests_bad;

  // Burst results with one slot per beat
  line_ram_pkg::word_t burst_dat [line_ram_pkg::WORDS_PER_LINE];
  int                  burst_edges [line_ram_pkg::WORDS_PER_LINE];

  // ==============================
  // Checks
  // ==============================
  task automatic check_word(input string name, input line_ram_pkg::word_t exp,
                            input line_ram_pkg::word_t act);
    assert (act === exp) else begin
      $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    assert (act == exp) else begin
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Stops the run when a wait expires
  task automatic abort_run(input string msg);
    $display("ERROR at t=%0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // One result line per test
  task automatic finish_test(input string name, input int err_base);
    if (err_cnt == err_base) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, err_cnt - err_base);
    end
  endtask

  `include "tb_wb_line_ram_tasks.svh"

  // First beat after the latency and later beats in the same cycle
  task automatic check_burst(input line_ram_pkg::byte_addr_t adr, input int beats);
    line_ram_pkg::byte_addr_t beat_adr;
    for (int i = 0; i < beats; i++) begin
      beat_adr = adr + line_ram_pkg::byte_addr_t'(4 * i);
      check_int("burst ack edges", (i == 0) ? READ_EDGES : 0, burst_edges[i]);
      check_word("burst wb_rsp.dat", model_word(beat_adr), burst_dat[i]);
    end
  endtask

  // 200 LFSR-chosen writes, reads and bursts
  task automatic run_random_mix();
    line_ram_pkg::byte_addr_t adr;
    line_ram_pkg::word_t      dat;
    line_ram_pkg::byte_sel_t  sel;
    logic [1:0]               op;
    logic                     gap;
    int                       edges;
    int                       beats;
    int                       off;
    // Whole memory filled first so every read has a known value
    for (int w = 0; w < line_ram_pkg::RAM_DEPTH_WORDS; w++) begin
      adr = line_ram_pkg::byte_addr_t'(4 * w);
      wb_write(adr, fill_pattern(adr), 4'b1111, edges);
    end
    for (int n = 0; n < 200; n++) begin
      op = 2'(rand_bits(2));
      case (op)
        2'd0: begin
          // Two extra address bits alias onto the same word
          adr = rand_bits(12) << 2;
          dat = rand_bits(32);
          sel = line_ram_pkg::byte_sel_t'(rand_bits(4));
          wb_write(adr, dat, sel, edges);
          check_int("write ack edges", 0, edges);
        end
        2'd1: begin
          adr = rand_bits(12) << 2;
          wb_read(adr, dat, edges);
          check_int("read ack edges", READ_EDGES, edges);
          check_word("wb_rsp.dat", model_word(adr), dat);
        end
        default: begin
          // 2 to 4 beats that never pass the end of the line
          beats = 2 + int'(rand_bits(2) % 3);
          off   = int'(rand_bits(2) % (5 - beats));
          adr   = (rand_bits(10) << 4) + line_ram_pkg::byte_addr_t'(4 * off);
          gap   = (rand_bits(1) != 0);
          wb_burst(adr, beats, gap);
          check_burst(adr, beats);
        end
      endcase
    end
  endtask

  wb_line_ram dut0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wb_req_i(wb_req),
    .wb_rsp_o(wb_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int                  base;
    int                  edges;
    line_ram_pkg::word_t rdat;
    wb_req    = '0;
    rst_ni    = 1'b0;
    err_cnt   = 0;
    tests_ok  = 0;
    tests_bad = 0;

    // Ack quiet in reset and two cycles after
    base = err_cnt;
    repeat (4) begin
      @(posedge clk_i);
      #1;
      check_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);
    end
    rst_ni = 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      #1;
      check_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);
    end
    finish_test("reset", base);

    // Partial selects merge into one word
    base = err_cnt;
    wb_write(32'h0000_0040, 32'h1122_3344, 4'b1111, edges);
    wb_write(32'h0000_0040, 32'haabb_ccdd, 4'b0101, edges);
    wb_write(32'h0000_0040, 32'h5566_7788, 4'b1000, edges);
    wb_read(32'h0000_0040, rdat, edges);
    check_word("wb_rsp.dat", model_word(32'h0000_0040), rdat);
    finish_test("byte_select", base);

    // Write acked at once and read after the full latency
    base = err_cnt;
    wb_write(32'h0000_0080, 32'hcafe_f00d, 4'b1111, edges);
    check_int("write ack edges", 0, edges);
    wb_read(32'h0000_0080, rdat, edges);
    check_int("read ack edges", READ_EDGES, edges);
    check_word("wb_rsp.dat", model_word(32'h0000_0080), rdat);
    finish_test("read_latency", base);

    // Four beats across one whole line
    base = err_cnt;
    for (int w = 0; w < 4; w++) begin
      wb_write(32'h0000_0100 + line_ram_pkg::byte_addr_t'(4 * w), rand_bits(32), 4'b1111, edges);
    end
    wb_burst(32'h0000_0100, 4, 1'b0);
    check_burst(32'h0000_0100, 4);
    finish_test("full_burst", base);

    // Short burst followed by a fresh fetch of the line
    base = err_cnt;
    for (int w = 0; w < 4; w++) begin
      wb_write(32'h0000_0200 + line_ram_pkg::byte_addr_t'(4 * w), rand_bits(32), 4'b1111, edges);
    end
    wb_burst(32'h0000_0204, 2, 1'b0);
    check_burst(32'h0000_0204, 2);
    wb_write(32'h0000_0208, 32'h600d_da7a, 4'b1111, edges);
    wb_read(32'h0000_0208, rdat, edges);
    check_int("read ack edges", READ_EDGES, edges);
    check_word("wb_rsp.dat", 32'h600d_da7a, rdat);
    finish_test("line_release", base);

    base = err_cnt;
    run_random_mix();
    finish_test("random_mix", base);

    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: wb_line_ram.f
+incdir+sim
hdl/line_ram_pkg.sv
hdl/wb_lane_expand.sv
hdl/line_store.sv
hdl/read_latency_pipe.sv
hdl/burst_line_buffer.sv
hdl/wb_line_ram.sv
sim/tb_wb_line_ram.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Wishbone line RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f wb_line_ram.f \
  --top-module tb_wb_line_ram \
  --Mdir obj_dir

output=$(./obj_dir/Vtb_wb_line_ram)
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi
